//--- hdl/msu_reg_pkg.sv
package msu_reg_pkg;

  ////////////////////
  // Host register window

  // Encoded by write meaning; reads reuse the same three address bits
  typedef enum logic [2:0] {
    REG_SEEK0      = 3'd0,
    REG_SEEK1      = 3'd1,
    REG_SEEK2      = 3'd2,
    REG_SEEK3      = 3'd3,
    REG_TRACK_LO   = 3'd4,
    REG_TRACK_HI   = 3'd5,
    REG_VOLUME     = 3'd6,
    REG_AUDIO_CTRL = 3'd7
  } msu_reg_addr_t;

  // Read side names for the first two addresses
  localparam msu_reg_addr_t REG_STATUS = REG_SEEK0;
  localparam msu_reg_addr_t REG_DATA   = REG_SEEK1;

  // Positions in the controller set/reset vectors, bit 3 is spare
  typedef enum logic [2:0] {
    STAT_CTRL_PEND  = 3'd0,
    STAT_AUDIO_ST0  = 3'd1,
    STAT_AUDIO_ST1  = 3'd2,
    STAT_DATA_BUSY  = 3'd4,
    STAT_AUDIO_BUSY = 3'd5
  } msu_status_bit_t;

  // ID string at addresses 2..7, element 0 is the first character
  localparam logic [0:5][7:0] MSU_ID = "S-MSU1";

  localparam logic [3:0] MSU_REVISION = 4'h1;

endpackage

//--- hdl/msu_cmd_pkg.sv
package msu_cmd_pkg;

  ////////////////////
  // Command stream to the media controller

  localparam int MSU_CMD_OP_W  = 2;
  localparam int MSU_CMD_ARG_W = 32;

  // Source field widths, zero-extended into the argument
  localparam int MSU_SEEK_W   = 32;
  localparam int MSU_TRACK_W  = 16;
  localparam int MSU_VOLUME_W = 8;
  localparam int MSU_CTRL_W   = 2;

  typedef enum logic [MSU_CMD_OP_W-1:0] {
    // Data seek address
    CMD_SEEK   = 2'd0,
    // Start a track
    CMD_PLAY   = 2'd1,
    // New volume level
    CMD_VOLUME = 2'd2,
    // Audio repeat/play control
    CMD_CTRL   = 2'd3
  } msu_cmd_op_t;

endpackage

//--- hdl/msu_bus_sync.sv
module msu_bus_sync (
  input  logic clkin,
  input  logic rst,
  input  logic reg_we,
  input  logic reg_oe,
  input  logic status_reset_we,
  input  logic msu_address_ext_write,
  output logic we_rise,
  output logic oe_fall,
  output logic status_upd,
  output logic ext_load
);

  // Bit 0 and 1 synchronize, bit 2 keeps the previous synchronized level
  logic [2:0] we_sr;
  logic [2:0] oe_sr;
  logic [2:0] upd_sr;
  logic [2:0] ld_sr;

  ////////////////////
  // Sync and edge detect

  always_ff @(posedge clkin) begin
    if (rst) begin
      we_sr      <= '0;
      oe_sr      <= '0;
      upd_sr     <= '0;
      ld_sr      <= '0;
      we_rise    <= 1'b0;
      oe_fall    <= 1'b0;
      status_upd <= 1'b0;
      ext_load   <= 1'b0;
    end else begin
      we_sr  <= {we_sr[1:0], reg_we};
      oe_sr  <= {oe_sr[1:0], reg_oe};
      upd_sr <= {upd_sr[1:0], status_reset_we};
      ld_sr  <= {ld_sr[1:0], msu_address_ext_write};

      // Host write acts on the start of the strobe
      we_rise    <= we_sr[1] & ~we_sr[2];
      // Read completes when the host lets go of the output enable
      oe_fall    <= ~oe_sr[1] & oe_sr[2];
      status_upd <= upd_sr[1] & ~upd_sr[2];
      ext_load   <= ld_sr[1] & ~ld_sr[2];
    end
  end

endmodule

//--- hdl/msu_regs.sv
module msu_regs (
  input  logic                                  clkin,
  input  logic                                  rst,
  input  logic                                  enable,
  input  logic                                  we_rise,
  input  logic                                  status_upd,
  input  msu_reg_pkg::msu_reg_addr_t            reg_addr,
  input  logic [7:0]                            reg_data_in,
  input  logic [7:0]                            data_latch,
  input  logic [5:0]                            status_set_bits,
  input  logic [5:0]                            status_reset_bits,
  output logic [7:0]                            reg_data_out,
  output logic                                  cmd_push,
  output msu_cmd_pkg::msu_cmd_op_t              cmd_push_op,
  output logic [msu_cmd_pkg::MSU_CMD_ARG_W-1:0] cmd_push_arg
);

  import msu_reg_pkg::*;
  import msu_cmd_pkg::*;

  logic [MSU_SEEK_W-1:0]   seek_addr;
  logic [MSU_TRACK_W-1:0]  track;
  logic [MSU_VOLUME_W-1:0] volume;
  logic [MSU_CTRL_W-1:0]   audio_ctrl;
  logic                    data_busy;
  logic                    audio_busy;
  logic [1:0]              audio_status;
  logic                    wr_en;
  logic [2:0]              id_idx;

  assign wr_en  = we_rise & enable;
  assign id_idx = reg_addr - 3'd2;

  ////////////////////
  // Host write decode

  always_ff @(posedge clkin) begin
    if (rst) begin
      seek_addr   <= '0;
      track       <= '0;
      volume      <= '0;
      audio_ctrl  <= '0;
      cmd_push    <= 1'b0;
      cmd_push_op <= CMD_SEEK;
    end else begin
      cmd_push <= 1'b0;
      if (wr_en) begin
        case (reg_addr)
          REG_SEEK0:    seek_addr[7:0]   <= reg_data_in;
          REG_SEEK1:    seek_addr[15:8]  <= reg_data_in;
          REG_SEEK2:    seek_addr[23:16] <= reg_data_in;
          REG_SEEK3: begin
            seek_addr[31:24] <= reg_data_in;
            cmd_push         <= 1'b1;
            cmd_push_op      <= CMD_SEEK;
          end
          REG_TRACK_LO: track[7:0] <= reg_data_in;
          REG_TRACK_HI: begin
            track[15:8] <= reg_data_in;
            cmd_push    <= 1'b1;
            cmd_push_op <= CMD_PLAY;
          end
          REG_VOLUME: begin
            volume      <= reg_data_in;
            cmd_push    <= 1'b1;
            cmd_push_op <= CMD_VOLUME;
          end
          REG_AUDIO_CTRL: begin
            // Control is ignored until the current track start is done
            if (!audio_busy) begin
              audio_ctrl  <= reg_data_in[MSU_CTRL_W-1:0];
              cmd_push    <= 1'b1;
              cmd_push_op <= CMD_CTRL;
            end
          end
        endcase
      end
    end
  end

  // Argument follows the registers that were just written
  always_comb begin
    case (cmd_push_op)
      CMD_SEEK:   cmd_push_arg = MSU_CMD_ARG_W'(seek_addr);
      CMD_PLAY:   cmd_push_arg = MSU_CMD_ARG_W'(track);
      CMD_VOLUME: cmd_push_arg = MSU_CMD_ARG_W'(volume);
      CMD_CTRL:   cmd_push_arg = MSU_CMD_ARG_W'(audio_ctrl);
    endcase
  end

  ////////////////////
  // Status flags

  always_ff @(posedge clkin) begin
    if (rst) begin
      data_busy    <= 1'b0;
      audio_busy   <= 1'b0;
      audio_status <= '0;
    end else begin
      if (status_upd) begin
        data_busy <= (data_busy | status_set_bits[STAT_DATA_BUSY])
                     & ~status_reset_bits[STAT_DATA_BUSY];
        audio_busy <= (audio_busy | status_set_bits[STAT_AUDIO_BUSY])
                      & ~status_reset_bits[STAT_AUDIO_BUSY];
        audio_status <= (audio_status | status_set_bits[STAT_AUDIO_ST1:STAT_AUDIO_ST0])
                        & ~status_reset_bits[STAT_AUDIO_ST1:STAT_AUDIO_ST0];
      end
      // A new request wins over a same-cycle controller update
      if (wr_en && reg_addr == REG_SEEK3) data_busy <= 1'b1;
      if (wr_en && reg_addr == REG_TRACK_HI) audio_busy <= 1'b1;
    end
  end

  // Read mux, one cycle behind the address
  always_ff @(posedge clkin) begin
    case (reg_addr)
      REG_STATUS: reg_data_out <= {data_busy, audio_busy, audio_status, MSU_REVISION};
      REG_DATA:   reg_data_out <= data_latch;
      default:    reg_data_out <= MSU_ID[id_idx];
    endcase
  end

endmodule

//--- hdl/msu_databuf.sv
module msu_databuf #(
  parameter int BUF_AW = 14
) (
  input  logic              clkin,
  input  logic              wr_en,
  input  logic [BUF_AW-1:0] wr_addr,
  input  logic [7:0]        wr_data,
  input  logic [BUF_AW-1:0] rd_addr,
  output logic [7:0]        rd_data
);

  // One byte per entry, maps onto block RAM
  logic [7:0] mem [2**BUF_AW];

  // Loader side
  always_ff @(posedge clkin) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Streaming side, registered output
  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- hdl/msu_data_port.sv
module msu_data_port #(
  parameter int BUF_AW = 14
) (
  input  logic                       clkin,
  input  logic                       rst,
  input  logic                       enable,
  input  logic                       ext_load,
  input  logic [BUF_AW-1:0]          ext_addr,
  input  logic                       oe_fall,
  input  msu_reg_pkg::msu_reg_addr_t reg_addr,
  output logic [BUF_AW-1:0]          buf_addr,
  input  logic [7:0]                 buf_data,
  output logic [7:0]                 data_latch
);

  import msu_reg_pkg::*;

  logic [BUF_AW-1:0] rd_ptr;
  logic              data_rd;

  // Finished host read of the data register
  assign data_rd = enable & oe_fall & (reg_addr == REG_DATA);

  // RAM is addressed by the pointer at all times
  assign buf_addr = rd_ptr;

  ////////////////////
  // Read pointer

  always_ff @(posedge clkin) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (ext_load) begin
      rd_ptr <= ext_addr;
    end else if (data_rd) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Byte presented on the next DATA read
  always_ff @(posedge clkin) begin
    if (rst) begin
      data_latch <= '0;
    end else if (data_rd) begin
      data_latch <= buf_data;
    end
  end

endmodule

//--- hdl/msu_cmd_queue.sv
module msu_cmd_queue #(
  parameter int QUEUE_DEPTH = 4,
  parameter int CREDITS     = 2
) (
  input  logic                                  clkin,
  input  logic                                  rst,
  input  logic                                  cmd_push,
  input  msu_cmd_pkg::msu_cmd_op_t              cmd_push_op,
  input  logic [msu_cmd_pkg::MSU_CMD_ARG_W-1:0] cmd_push_arg,
  output logic                                  cmd_valid,
  output msu_cmd_pkg::msu_cmd_op_t              cmd_op,
  output logic [msu_cmd_pkg::MSU_CMD_ARG_W-1:0] cmd_arg,
  input  logic                                  cmd_credit,
  output logic                                  cmd_overflow
);

  import msu_cmd_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int CRD_W = $clog2(CREDITS + 1);

  msu_cmd_op_t              op_mem  [QUEUE_DEPTH];
  logic [MSU_CMD_ARG_W-1:0] arg_mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [CNT_W-1:0]         count;
  logic [CRD_W-1:0]         credit_cnt;
  logic                     send;
  logic                     accept;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Head goes out whenever the controller has room for it
  assign send   = (count != '0) && (credit_cnt != '0);
  // A slot freed by this cycle's send can take the push
  assign accept = cmd_push && ((count != CNT_W'(QUEUE_DEPTH)) || send);

  assign cmd_valid = send;
  assign cmd_op    = op_mem[rd_ptr];
  assign cmd_arg   = arg_mem[rd_ptr];

  always_ff @(posedge clkin) begin
    if (accept) begin
      op_mem[wr_ptr]  <= cmd_push_op;
      arg_mem[wr_ptr] <= cmd_push_arg;
    end
  end

  ////////////////////
  // Pointers and credits

  always_ff @(posedge clkin) begin
    if (rst) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      credit_cnt   <= CRD_W'(CREDITS);
      cmd_overflow <= 1'b0;
    end else begin
      if (accept) wr_ptr <= next_ptr(wr_ptr);
      if (send) rd_ptr <= next_ptr(rd_ptr);
      case ({accept, send})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Send and return together cancel out
      if (send && !cmd_credit) begin
        credit_cnt <= credit_cnt - 1'b1;
      end else if (!send && cmd_credit && credit_cnt != CRD_W'(CREDITS)) begin
        credit_cnt <= credit_cnt + 1'b1;
      end
      if (cmd_push && !accept) cmd_overflow <= 1'b1;
    end
  end

endmodule

//--- hdl/msu_top.sv
module msu_top #(
  parameter int BUF_AW      = 14,
  parameter int QUEUE_DEPTH = 4,
  parameter int CREDITS     = 2
) (
  input  logic                                  clkin,
  input  logic                                  rst,
  input  logic                                  enable,
  input  logic [BUF_AW-1:0]                     pgm_address,
  input  logic [7:0]                            pgm_data,
  input  logic                                  pgm_we,
  input  msu_reg_pkg::msu_reg_addr_t            reg_addr,
  input  logic [7:0]                            reg_data_in,
  output logic [7:0]                            reg_data_out,
  input  logic                                  reg_oe,
  input  logic                                  reg_we,
  input  logic [5:0]                            status_reset_bits,
  input  logic [5:0]                            status_set_bits,
  input  logic                                  status_reset_we,
  input  logic [BUF_AW-1:0]                     msu_address_ext,
  input  logic                                  msu_address_ext_write,
  output logic                                  cmd_valid,
  output msu_cmd_pkg::msu_cmd_op_t              cmd_op,
  output logic [msu_cmd_pkg::MSU_CMD_ARG_W-1:0] cmd_arg,
  input  logic                                  cmd_credit,
  output logic                                  cmd_overflow
);

  import msu_cmd_pkg::*;

  logic                     we_rise;
  logic                     oe_fall;
  logic                     status_upd;
  logic                     ext_load;
  logic [7:0]               data_latch;
  logic [BUF_AW-1:0]        buf_addr;
  logic [7:0]               buf_data;
  logic                     cmd_push;
  msu_cmd_op_t              cmd_push_op;
  logic [MSU_CMD_ARG_W-1:0] cmd_push_arg;

  ////////////////////
  // Stage 1 and 2

  msu_bus_sync u_sync (
    .clkin, .rst, .reg_we, .reg_oe, .status_reset_we, .msu_address_ext_write,
    .we_rise, .oe_fall, .status_upd, .ext_load
  );

  msu_regs u_regs (
    .clkin, .rst, .enable, .we_rise, .status_upd, .reg_addr, .reg_data_in,
    .data_latch, .status_set_bits, .status_reset_bits, .reg_data_out,
    .cmd_push, .cmd_push_op, .cmd_push_arg
  );

  ////////////////////
  // Stage 3

  msu_databuf #(.BUF_AW(BUF_AW)) u_databuf (
    .clkin, .wr_en(pgm_we), .wr_addr(pgm_address), .wr_data(pgm_data),
    .rd_addr(buf_addr), .rd_data(buf_data)
  );

  msu_data_port #(.BUF_AW(BUF_AW)) u_data_port (
    .clkin, .rst, .enable, .ext_load, .ext_addr(msu_address_ext), .oe_fall,
    .reg_addr, .buf_addr, .buf_data, .data_latch
  );

  msu_cmd_queue #(.QUEUE_DEPTH(QUEUE_DEPTH), .CREDITS(CREDITS)) u_cmd_queue (
    .clkin, .rst, .cmd_push, .cmd_push_op, .cmd_push_arg,
    .cmd_valid, .cmd_op, .cmd_arg, .cmd_credit, .cmd_overflow
  );

endmodule

//--- test/tb_clock.sv
module tb_clock #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic clkin,
  output logic rst
);

  initial begin
    clkin = 1'b0;
    forever #(PERIOD / 2) clkin = ~clkin;
  end

  // Reset held from time zero, released on a rising edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clkin);
    rst <= 1'b0;
  end

endmodule

//--- test/msu_props.sv
module msu_props #(
  parameter int CREDITS = 2,
  parameter int CRD_W   = 2
) (
  input logic             clkin,
  input logic             rst,
  input logic             cmd_valid,
  input logic             cmd_credit,
  input logic [CRD_W-1:0] credit_cnt
);

  // Commands sent and not yet paid back by the controller
  int in_flight;

  always_ff @(posedge clkin) begin
    if (rst) begin
      in_flight <= 0;
    end else if (cmd_valid && !cmd_credit) begin
      in_flight <= in_flight + 1;
    end else if (!cmd_valid && cmd_credit && in_flight > 0) begin
      in_flight <= in_flight - 1;
    end
  end

  ////////////////////
  // Credit flow control

  // No send once every credit is out with the controller
  a_send_needs_credit: assert property (
    @(posedge clkin) disable iff (rst) cmd_valid |-> (in_flight < CREDITS)
  ) else $error("cmd_valid raised with zero credits");

  // Returned credits saturate at the initial count
  a_credit_bound: assert property (
    @(posedge clkin) disable iff (rst) credit_cnt <= CRD_W'(CREDITS)
  ) else $error("credit count above its initial value");

  // Queue comes out of reset idle
  a_idle_after_reset: assert property (
    @(posedge clkin) rst |=> !cmd_valid
  ) else $error("cmd_valid high right after reset");

endmodule

bind msu_cmd_queue msu_props #(.CREDITS(CREDITS), .CRD_W(CRD_W)) u_props (
  .clkin(clkin),
  .rst(rst),
  .cmd_valid(cmd_valid),
  .cmd_credit(cmd_credit),
  .credit_cnt(credit_cnt)
);

//--- test/msu_tb.sv
module msu_tb;

  import msu_reg_pkg::*;
  import msu_cmd_pkg::*;

  localparam int BUF_AW      = 14;
  localparam int QUEUE_DEPTH = 4;
  localparam int CREDITS     = 2;
  // Rough count of host and controller accesses over all tests
  localparam int HOST_ACCESSES = 110;
  localparam logic [BUF_AW-1:0] LOAD_BASE = 14'h1230;

  logic clkin;
  logic rst;
  logic enable;
  logic [BUF_AW-1:0] pgm_address;
  logic [7:0] pgm_data;
  logic pgm_we;
  msu_reg_addr_t reg_addr;
  logic [7:0] reg_data_in;
  logic [7:0] reg_data_out;
  logic reg_oe;
  logic reg_we;
  logic [5:0] status_reset_bits;
  logic [5:0] status_set_bits;
  logic status_reset_we;
  logic [BUF_AW-1:0] msu_address_ext;
  logic msu_address_ext_write;
  logic cmd_valid;
  msu_cmd_op_t cmd_op;
  logic [MSU_CMD_ARG_W-1:0] cmd_arg;
  logic cmd_credit = 1'b0;
  logic cmd_overflow;

  // Media controller side
  msu_cmd_op_t rx_op [$];
  logic [MSU_CMD_ARG_W-1:0] rx_arg [$];
  int credit_due [$];
  int cyc = 0;
  logic credit_pause = 1'b0;
  // Expected controller flags in the set/reset bit layout
  logic [5:0] flags = '0;
  string id_str = "S-MSU1";
  logic run_ended = 1'b0;

  tb_clock #(.PERIOD(100), .RESET_CYCLES(10)) u_clock (.clkin(clkin), .rst(rst));

  msu_top #(.BUF_AW(BUF_AW), .QUEUE_DEPTH(QUEUE_DEPTH), .CREDITS(CREDITS)) u_dut (
    .clkin(clkin), .rst(rst), .enable(enable),
    .pgm_address(pgm_address), .pgm_data(pgm_data), .pgm_we(pgm_we),
    .reg_addr(reg_addr), .reg_data_in(reg_data_in), .reg_data_out(reg_data_out),
    .reg_oe(reg_oe), .reg_we(reg_we),
    .status_reset_bits(status_reset_bits), .status_set_bits(status_set_bits),
    .status_reset_we(status_reset_we),
    .msu_address_ext(msu_address_ext), .msu_address_ext_write(msu_address_ext_write),
    .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_arg(cmd_arg),
    .cmd_credit(cmd_credit), .cmd_overflow(cmd_overflow)
  );

  // Controller model returns one credit 3 cycles after each command
  always @(posedge clkin) begin
    cyc = cyc + 1;
    if (rst) begin
      cmd_credit <= 1'b0;
    end else begin
      if (cmd_valid) begin
        rx_op.push_back(cmd_op);
        rx_arg.push_back(cmd_arg);
        credit_due.push_back(cyc + 3);
      end
      if (!credit_pause && credit_due.size() > 0 && credit_due[0] <= cyc) begin
        cmd_credit <= 1'b1;
        void'(credit_due.pop_front());
      end else begin
        cmd_credit <= 1'b0;
      end
    end
  end

  task automatic stop_with_failure(input string why);
    run_ended = 1'b1;
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped on first failure");
  endtask

  ////////////////////
  // Compare tasks

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
      stop_with_failure($sformatf("error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_cmd(input string name, input msu_cmd_op_t exp_op,
                           input logic [MSU_CMD_ARG_W-1:0] exp_arg,
                           input msu_cmd_op_t act_op, input logic [MSU_CMD_ARG_W-1:0] act_arg);
    if (act_op !== exp_op || act_arg !== exp_arg)
      stop_with_failure($sformatf("error %s: expected %s %h, actual %s %h", name,
                                  exp_op.name(), exp_arg, act_op.name(), act_arg));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      stop_with_failure($sformatf("error %s: expected %b, actual %b", name, exp, act));
  endtask

  ////////////////////
  // Host and controller access

  task automatic host_write(input msu_reg_addr_t addr, input logic [7:0] data);
    @(posedge clkin);
    reg_addr    <= addr;
    reg_data_in <= data;
    reg_we      <= 1'b1;
    repeat (6) @(posedge clkin);
    reg_we <= 1'b0;
    repeat (3) @(posedge clkin);
    if (addr == REG_SEEK3) flags[4] = 1'b1;
    if (addr == REG_TRACK_HI) flags[5] = 1'b1;
  endtask

  task automatic host_read(input msu_reg_addr_t addr, output logic [7:0] data);
    @(posedge clkin);
    reg_addr <= addr;
    reg_oe   <= 1'b1;
    repeat (6) @(posedge clkin);
    reg_oe <= 1'b0;
    // Falling edge sync, latch, then the registered read mux
    repeat (7) @(posedge clkin);
    data = reg_data_out;
  endtask

  task automatic controller_status(input logic [5:0] set, input logic [5:0] clr);
    @(posedge clkin);
    status_set_bits   <= set;
    status_reset_bits <= clr;
    status_reset_we   <= 1'b1;
    repeat (6) @(posedge clkin);
    status_reset_we <= 1'b0;
    repeat (3) @(posedge clkin);
    flags = (flags | set) & ~clr;
  endtask

  task automatic set_pointer(input logic [BUF_AW-1:0] addr);
    @(posedge clkin);
    msu_address_ext       <= addr;
    msu_address_ext_write <= 1'b1;
    repeat (6) @(posedge clkin);
    msu_address_ext_write <= 1'b0;
    repeat (4) @(posedge clkin);
  endtask

  function automatic logic [7:0] status_byte(input logic [5:0] f);
    return {f[4], f[5], f[2:1], MSU_REVISION};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic expect_cmd(input string name, input msu_cmd_op_t op,
                            input logic [MSU_CMD_ARG_W-1:0] arg);
    int waited;
    waited = 0;
    while (rx_op.size() == 0) begin
      @(posedge clkin);
      waited++;
      if (waited > 300) stop_with_failure($sformatf("%s: no command arrived", name));
    end
    check_cmd(name, op, arg, rx_op.pop_front(), rx_arg.pop_front());
  endtask

  task automatic expect_no_cmd(input string name);
    repeat (30) @(posedge clkin);
    if (rx_op.size() != 0)
      stop_with_failure($sformatf("%s: unexpected command %s", name, rx_op[0].name()));
  endtask

  ////////////////////
  // Directed tests

  task automatic test_reset_values();
    logic [7:0] got;
    host_read(REG_STATUS, got);
    check_byte("reset_status", 8'h01, got);
    for (int k = 2; k < 8; k++) begin
      host_read(msu_reg_addr_t'(k), got);
      check_byte($sformatf("reset_id%0d", k), id_str[k-2], got);
    end
  endtask

  task automatic test_data_stream();
    logic [31:0] seed;
    logic [7:0] bytes [64];
    logic [7:0] got;
    seed = 32'd7005;
    for (int i = 0; i < 64; i++) begin
      seed = lcg_next(seed);
      bytes[i] = seed[23:16];
      @(posedge clkin);
      pgm_we      <= 1'b1;
      pgm_address <= LOAD_BASE + BUF_AW'(i);
      pgm_data    <= bytes[i];
    end
    @(posedge clkin);
    pgm_we <= 1'b0;
    set_pointer(LOAD_BASE);
    for (int i = 0; i < 64; i++) begin
      host_read(REG_DATA, got);
      check_byte($sformatf("data_stream%0d", i), bytes[i], got);
    end
  endtask

  task automatic test_commands();
    logic [7:0] got;
    host_write(REG_SEEK0, 8'h78);
    host_write(REG_SEEK1, 8'h56);
    host_write(REG_SEEK2, 8'h34);
    host_write(REG_SEEK3, 8'h12);
    expect_cmd("seek", CMD_SEEK, 32'h1234_5678);
    expect_no_cmd("seek_once");
    host_read(REG_STATUS, got);
    check_byte("seek_status", status_byte(flags), got);
    host_write(REG_TRACK_LO, 8'h2a);
    host_write(REG_TRACK_HI, 8'h01);
    expect_cmd("play", CMD_PLAY, 32'h0000_012a);
    host_read(REG_STATUS, got);
    check_byte("play_status", status_byte(flags), got);
    host_write(REG_VOLUME, 8'hc8);
    expect_cmd("volume", CMD_VOLUME, 32'h0000_00c8);
  endtask

  task automatic test_ctrl_gating();
    host_write(REG_AUDIO_CTRL, 8'h03);
    expect_no_cmd("ctrl_while_busy");
    controller_status(6'b000000, 6'b100000);
    host_write(REG_AUDIO_CTRL, 8'h03);
    expect_cmd("ctrl", CMD_CTRL, 32'h0000_0003);
  endtask

  task automatic test_status_update();
    logic [7:0] got;
    controller_status(6'b100010, 6'b000000);
    host_read(REG_STATUS, got);
    check_byte("status_set", status_byte(flags), got);
    // Reset wins over a set of the same bit
    controller_status(6'b000100, 6'b010110);
    host_read(REG_STATUS, got);
    check_byte("status_set_reset", status_byte(flags), got);
  endtask

  task automatic test_backpressure();
    while (credit_due.size() != 0) @(posedge clkin);
    repeat (5) @(posedge clkin);
    credit_pause = 1'b1;
    // Two go out on credit, four fill the FIFO, the last is dropped
    for (int i = 0; i < 7; i++) begin
      if (i == 6) check_flag("overflow_before", 1'b0, cmd_overflow);
      host_write(REG_VOLUME, 8'h40 + 8'(i));
    end
    repeat (5) @(posedge clkin);
    check_flag("overflow_after", 1'b1, cmd_overflow);
    expect_cmd("bp_sent0", CMD_VOLUME, 32'h40);
    expect_cmd("bp_sent1", CMD_VOLUME, 32'h41);
    expect_no_cmd("bp_paused");
    credit_pause = 1'b0;
    for (int i = 2; i < 6; i++) begin
      expect_cmd($sformatf("bp_queued%0d", i), CMD_VOLUME, 32'h40 + 32'(i));
    end
    expect_no_cmd("bp_dropped");
  endtask

  // Watchdog
  initial begin
    repeat (200 * HOST_ACCESSES) @(posedge clkin);
    stop_with_failure("watchdog expired, the run hung");
  end

  // Run stopped by a failed assertion before the tests finished
  final begin
    if (!run_ended) begin
      $display("tests failed");
    end
  end

  initial begin
    enable                <= 1'b1;
    pgm_address           <= '0;
    pgm_data              <= '0;
    pgm_we                <= 1'b0;
    reg_addr              <= REG_STATUS;
    reg_data_in           <= '0;
    reg_oe                <= 1'b0;
    reg_we                <= 1'b0;
    status_reset_bits     <= '0;
    status_set_bits       <= '0;
    status_reset_we       <= 1'b0;
    msu_address_ext       <= '0;
    msu_address_ext_write <= 1'b0;
    wait (rst == 1'b0);
    @(posedge clkin);
    test_reset_values();
    test_data_stream();
    test_commands();
    test_ctrl_gating();
    test_status_update();
    test_backpressure();
    run_ended = 1'b1;
    $display("all tests passed");
    $finish;
  end

endmodule

//--- vlog.f
hdl/msu_reg_pkg.sv
hdl/msu_cmd_pkg.sv
hdl/msu_bus_sync.sv
hdl/msu_regs.sv
hdl/msu_databuf.sv
hdl/msu_data_port.sv
hdl/msu_cmd_queue.sv
hdl/msu_top.sv
test/tb_clock.sv
test/msu_props.sv
test/msu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= msu_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
